// ==== common/mpu_pkg.sv ====
`default_nettype none

package mpu_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  localparam int ADDR_W          = 32;
  localparam int DATA_W          = 32;
  localparam int PMA_NUM_REGIONS = 4;
  localparam int MAX_OUTSTANDING = 2;

  // Counter and queue pointer widths
  localparam int CNT_W       = $clog2(MAX_OUTSTANDING + 1);
  localparam int QUEUE_PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  typedef enum logic [1:0] {
    MPU_IDLE     = 2'b00,
    MPU_ERR_WAIT = 2'b01,
    MPU_ERR_RESP = 2'b10
  } mpu_state_e;

  //////////////////////////////////////////////////
  // Region attributes
  //////////////////////////////////////////////////

  // Bounds are word addresses, low inclusive and high exclusive
  typedef struct packed {
    logic [ADDR_W-3:0] word_addr_low;
    logic [ADDR_W-3:0] word_addr_high;
    logic              main;
    logic              bufferable;
    logic              cacheable;
  } pma_cfg_t;

  localparam pma_cfg_t PMA_R_DEFAULT = '{word_addr_low: '0, word_addr_high: '0,
                                         main: 1'b1, bufferable: 1'b0, cacheable: 1'b0};

  // Region 1 overlaps the upper half of region 0
  localparam pma_cfg_t PMA_CFG [PMA_NUM_REGIONS] = '{
    '{word_addr_low: 30'h0000_0000, word_addr_high: 30'h0000_4000,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b1},
    '{word_addr_low: 30'h0000_2000, word_addr_high: 30'h0000_8000,
      main: 1'b0, bufferable: 1'b0, cacheable: 1'b0},
    '{word_addr_low: 30'h0400_0000, word_addr_high: 30'h0400_4000,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b0},
    '{word_addr_low: 30'h0800_0000, word_addr_high: 30'h0800_0400,
      main: 1'b0, bufferable: 1'b0, cacheable: 1'b0}
  };

  //////////////////////////////////////////////////
  // Transfers
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic              misaligned;
  } core_req_t;

  // memtype bit 0 bufferable, bit 1 cacheable
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic [1:0]        memtype;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    mpu_status_e       status;
  } core_resp_t;

endpackage

`default_nettype wire

// ==== mpu_port/pma_lookup.sv ====
`timescale 1ns/100ps
`default_nettype none

module pma_lookup import mpu_pkg::*; (
  input  wire logic [ADDR_W-1:0] addr_i,
  input  wire logic              instr_side_i,
  input  wire logic              we_i,
  input  wire logic              misaligned_i,
  output logic                   err_o,
  output logic [1:0]             memtype_o
);

  logic [ADDR_W-3:0] word_addr;
  logic [PMA_NUM_REGIONS-1:0] hit;
  pma_cfg_t cfg;

  // The two low address bits never take part in matching
  assign word_addr = addr_i[ADDR_W-1:2];

  //////////////////////////////////////////////////
  // Region match
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      hit[i] = (word_addr >= PMA_CFG[i].word_addr_low) &&
               (word_addr < PMA_CFG[i].word_addr_high);
    end
  end

  // Walk down from the top so the lowest matching index is the last written
  always_comb begin
    cfg = PMA_R_DEFAULT;
    for (int i = PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (hit[i]) begin
        cfg = PMA_CFG[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // Attribute decision
  //////////////////////////////////////////////////

  // Fetches and misaligned accesses are only allowed in main memory
  assign err_o = (instr_side_i || misaligned_i) && !cfg.main;

  assign memtype_o[1] = cfg.cacheable;
  // Bufferable only applies to data writes
  assign memtype_o[0] = cfg.bufferable && we_i && !instr_side_i;

endmodule

`default_nettype wire

// ==== mpu_port/mpu_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module mpu_port import mpu_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,

  // Core side
  input  wire logic              core_req_valid_i,
  input  wire core_req_t         core_req_i,
  output logic                   core_req_ready_o,
  output logic                   core_resp_valid_o,
  output core_resp_t             core_resp_o,

  // Toward the arbiter
  output bus_req_t               bus_req_o,
  output logic                   bus_req_valid_o,
  input  wire logic              bus_req_ready_i,
  input  wire logic              bus_resp_valid_i,
  input  wire logic [DATA_W-1:0] bus_rdata_i,

  input  wire logic              instr_side_i
);

  logic             pma_err;
  logic [1:0]       pma_memtype;
  logic             idle;
  logic             err_accept;
  logic             bus_accept;
  logic             err_resp;
  mpu_state_e       state_q;
  mpu_state_e       state_d;
  logic             err_we_q;
  logic [CNT_W-1:0] outstanding_q;
  logic [CNT_W-1:0] outstanding_d;

  pma_lookup i_pma_lookup (
    .addr_i       (core_req_i.addr),
    .instr_side_i (instr_side_i),
    .we_i         (core_req_i.we),
    .misaligned_i (core_req_i.misaligned),
    .err_o        (pma_err),
    .memtype_o    (pma_memtype)
  );

  //////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////

  assign idle = (state_q == MPU_IDLE);

  assign bus_req_o.addr    = core_req_i.addr;
  assign bus_req_o.we      = core_req_i.we;
  assign bus_req_o.wdata   = core_req_i.wdata;
  assign bus_req_o.memtype = pma_memtype;

  // Blocked requests never reach the arbiter
  assign bus_req_valid_o = core_req_valid_i && !pma_err && idle;

  // A blocked request is taken at once, an allowed one waits for a grant
  assign core_req_ready_o = idle && (pma_err ? core_req_valid_i : bus_req_ready_i);

  assign err_accept = core_req_valid_i && pma_err && idle;
  assign bus_accept = bus_req_valid_o && bus_req_ready_i;

  //////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////

  assign err_resp = (state_q == MPU_ERR_RESP);

  assign core_resp_valid_o  = bus_resp_valid_i || err_resp;
  assign core_resp_o.rdata  = err_resp ? '0 : bus_rdata_i;
  assign core_resp_o.status = !err_resp ? MPU_OK  :
                              err_we_q  ? MPU_WR_FAULT : MPU_RE_FAULT;

  // Own transactions still on the bus
  always_comb begin
    outstanding_d = outstanding_q;
    if (bus_accept && !bus_resp_valid_i) begin
      outstanding_d = outstanding_q + CNT_W'(1);
    end else if (!bus_accept && bus_resp_valid_i) begin
      outstanding_d = outstanding_q - CNT_W'(1);
    end
  end

  //////////////////////////////////////////////////
  // Error response FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MPU_IDLE: begin
        if (err_accept) begin
          state_d = (outstanding_d == '0) ? MPU_ERR_RESP : MPU_ERR_WAIT;
        end
      end
      // Hold the fault back until earlier reads are answered
      MPU_ERR_WAIT: begin
        if (outstanding_d == '0) begin
          state_d = MPU_ERR_RESP;
        end
      end
      MPU_ERR_RESP: state_d = MPU_IDLE;
      default:      state_d = MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= MPU_IDLE;
      err_we_q      <= 1'b0;
      outstanding_q <= '0;
    end else begin
      state_q       <= state_d;
      outstanding_q <= outstanding_d;
      if (err_accept) begin
        err_we_q <= core_req_i.we;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/bus_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter import mpu_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,

  input  wire bus_req_t instr_req_i,
  input  wire logic     instr_valid_i,
  output logic          instr_ready_o,

  input  wire bus_req_t data_req_i,
  input  wire logic     data_valid_i,
  output logic          data_ready_o,

  output bus_req_t      bus_req_o,
  output logic          bus_req_valid_o,
  input  wire logic     bus_req_ready_i,
  input  wire logic     bus_resp_valid_i,

  output logic          instr_resp_valid_o,
  output logic          data_resp_valid_o
);

  logic                   sel_data;
  logic                   queue_full;
  logic                   can_issue;
  logic                   push;
  logic                   pop;
  logic                   head_data;
  logic                   prio_data_q;
  logic                   lock_q;
  logic                   lock_sel_q;
  logic [CNT_W-1:0]       count_q;
  logic [QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [QUEUE_PTR_W-1:0] rd_ptr_q;
  logic                   id_mem_q [MAX_OUTSTANDING];

  function automatic logic [QUEUE_PTR_W-1:0] ptr_inc(input logic [QUEUE_PTR_W-1:0] ptr);
    logic [QUEUE_PTR_W-1:0] last;
    last = QUEUE_PTR_W'(MAX_OUTSTANDING - 1);
    return (ptr == last) ? '0 : ptr + QUEUE_PTR_W'(1);
  endfunction

  //////////////////////////////////////////////////
  // Grant
  //////////////////////////////////////////////////

  // A request left waiting on the bus keeps its grant
  always_comb begin
    if (lock_q) begin
      sel_data = lock_sel_q;
    end else if (instr_valid_i && data_valid_i) begin
      sel_data = prio_data_q;
    end else begin
      sel_data = data_valid_i;
    end
  end

  assign queue_full      = (count_q == CNT_W'(MAX_OUTSTANDING));
  assign can_issue       = bus_req_ready_i && !queue_full;
  assign bus_req_valid_o = (instr_valid_i || data_valid_i) && !queue_full;
  assign bus_req_o       = sel_data ? data_req_i : instr_req_i;
  assign instr_ready_o   = can_issue && instr_valid_i && !sel_data;
  assign data_ready_o    = can_issue && data_valid_i && sel_data;

  //////////////////////////////////////////////////
  // In-order response routing
  //////////////////////////////////////////////////

  assign push      = bus_req_valid_o && bus_req_ready_i;
  assign pop       = bus_resp_valid_i && (count_q != '0);
  assign head_data = id_mem_q[rd_ptr_q];

  assign instr_resp_valid_o = pop && !head_data;
  assign data_resp_valid_o  = pop && head_data;

  always_ff @(posedge clk) begin
    if (push) begin
      id_mem_q[wr_ptr_q] <= sel_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_data_q <= 1'b1;
      lock_q      <= 1'b0;
      lock_sel_q  <= 1'b0;
      count_q     <= '0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
    end else begin
      lock_q     <= bus_req_valid_o && !bus_req_ready_i;
      lock_sel_q <= sel_data;
      if (push) begin
        prio_data_q <= !sel_data;
        wr_ptr_q    <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (!push && pop) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/mpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mpu_top import mpu_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,

  // Instruction fetch port
  input  wire logic              instr_core_req_valid_i,
  input  wire core_req_t         instr_core_req_i,
  output logic                   instr_core_req_ready_o,
  output logic                   instr_core_resp_valid_o,
  output core_resp_t             instr_core_resp_o,

  // Data port
  input  wire logic              data_core_req_valid_i,
  input  wire core_req_t         data_core_req_i,
  output logic                   data_core_req_ready_o,
  output logic                   data_core_resp_valid_o,
  output core_resp_t             data_core_resp_o,

  // Shared bus
  output bus_req_t               bus_req_o,
  output logic                   bus_req_valid_o,
  input  wire logic              bus_req_ready_i,
  input  wire logic              bus_resp_valid_i,
  input  wire logic [DATA_W-1:0] bus_rdata_i
);

  bus_req_t instr_bus_req;
  logic     instr_bus_valid;
  logic     instr_bus_ready;
  logic     instr_resp_valid;
  bus_req_t data_bus_req;
  logic     data_bus_valid;
  logic     data_bus_ready;
  logic     data_resp_valid;

  mpu_port i_instr_port (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (instr_core_req_valid_i),
    .core_req_i        (instr_core_req_i),
    .core_req_ready_o  (instr_core_req_ready_o),
    .core_resp_valid_o (instr_core_resp_valid_o),
    .core_resp_o       (instr_core_resp_o),
    .bus_req_o         (instr_bus_req),
    .bus_req_valid_o   (instr_bus_valid),
    .bus_req_ready_i   (instr_bus_ready),
    .bus_resp_valid_i  (instr_resp_valid),
    .bus_rdata_i       (bus_rdata_i),
    .instr_side_i      (1'b1)
  );

  mpu_port i_data_port (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (data_core_req_valid_i),
    .core_req_i        (data_core_req_i),
    .core_req_ready_o  (data_core_req_ready_o),
    .core_resp_valid_o (data_core_resp_valid_o),
    .core_resp_o       (data_core_resp_o),
    .bus_req_o         (data_bus_req),
    .bus_req_valid_o   (data_bus_valid),
    .bus_req_ready_i   (data_bus_ready),
    .bus_resp_valid_i  (data_resp_valid),
    .bus_rdata_i       (bus_rdata_i),
    .instr_side_i      (1'b0)
  );

  // Read data fans out to both ports, the arbiter steers only the valids
  bus_arbiter i_bus_arbiter (
    .clk                (clk),
    .rst_n              (rst_n),
    .instr_req_i        (instr_bus_req),
    .instr_valid_i      (instr_bus_valid),
    .instr_ready_o      (instr_bus_ready),
    .data_req_i         (data_bus_req),
    .data_valid_i       (data_bus_valid),
    .data_ready_o       (data_bus_ready),
    .bus_req_o          (bus_req_o),
    .bus_req_valid_o    (bus_req_valid_o),
    .bus_req_ready_i    (bus_req_ready_i),
    .bus_resp_valid_i   (bus_resp_valid_i),
    .instr_resp_valid_o (instr_resp_valid),
    .data_resp_valid_o  (data_resp_valid)
  );

endmodule

`default_nettype wire

// ==== tests/mpu_model.svh ====
`ifndef MPU_MODEL_SVH
`define MPU_MODEL_SVH

`default_nettype none

//////////////////////////////////////////////////
// Region table as byte ranges
//////////////////////////////////////////////////

// Lowest index is tested first, 4 stands for the default region
function automatic int unsigned region_of(input logic [31:0] addr);
  if (addr < 32'h0001_0000) begin
    return 0;
  end
  if (addr >= 32'h0000_8000 && addr < 32'h0002_0000) begin
    return 1;
  end
  if (addr >= 32'h1000_0000 && addr < 32'h1001_0000) begin
    return 2;
  end
  if (addr >= 32'h2000_0000 && addr < 32'h2000_1000) begin
    return 3;
  end
  return 4;
endfunction

// Regions 1 and 3 are I/O, the default region is main memory
function automatic logic is_main(input int unsigned region);
  return !(region == 1 || region == 3);
endfunction

function automatic logic is_cacheable(input int unsigned region);
  return region == 0;
endfunction

function automatic logic is_bufferable(input int unsigned region);
  return region == 0 || region == 2;
endfunction

//////////////////////////////////////////////////
// Access decision
//////////////////////////////////////////////////

// Fetches and misaligned accesses to I/O are refused
function automatic logic access_blocked(input logic [31:0] addr, input logic instr_side,
                                        input logic misaligned);
  return (instr_side || misaligned) && !is_main(region_of(addr));
endfunction

// Bit 1 cacheable, bit 0 bufferable for data writes only
function automatic logic [1:0] expected_memtype(input logic [31:0] addr,
                                                input logic instr_side, input logic we);
  int unsigned region;
  region = region_of(addr);
  return {is_cacheable(region), is_bufferable(region) && we && !instr_side};
endfunction

function automatic logic [31:0] expected_rdata(input logic [31:0] addr);
  return addr ^ 32'h5A5A_0000;
endfunction

`default_nettype wire

`endif

// ==== tests/tb_mpu_top.sv ====
`timescale 1ns/100ps
`include "mpu_model.svh"
`default_nettype none

module tb_mpu_top import mpu_pkg::*; ();

  localparam int          CLK_HALF      = 20;
  localparam int          DRIVE_DELAY   = 2;
  localparam int          RESET_CYCLES  = 10;
  localparam int          RUN_CYCLES    = 4000;
  localparam int          REQ_TIMEOUT   = 100;
  localparam int          DRAIN_TIMEOUT = 200;
  localparam int          MAX_PASSED    = 4;
  localparam logic [31:0] SEED          = 32'h4008a94b;

  typedef struct packed {
    logic        blocked;
    logic [31:0] rdata;
    logic [1:0]  status;
  } exp_resp_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] due;
  } bus_entry_t;

  logic        clk = 1'b0;
  logic        rst_n;
  // Index 0 is the instruction port, index 1 the data port
  logic        core_valid [2];
  core_req_t   core_req [2];
  logic        core_ready [2];
  logic        resp_valid [2];
  core_resp_t  resp [2];
  bus_req_t    bus_req;
  logic        bus_valid;
  logic        bus_ready;
  logic        bus_resp_valid;
  logic [31:0] bus_rdata;

  exp_resp_t   exp_q [2][$];
  bus_entry_t  bus_q [$];
  logic        taken [2];
  logic        fault_armed [2];
  int unsigned fault_due [2];
  int unsigned outstanding [2];
  int unsigned pend_cycles [2];
  int unsigned passed_over [2];
  int unsigned accepted [2];
  int unsigned cycle;
  int unsigned check_count;
  int unsigned error_count;
  logic        timed_out;

  localparam logic [31:0] EDGE_ADDRS [14] = '{
    32'h0000_7FFC, 32'h0000_8000, 32'h0000_FFFC, 32'h0001_0000,
    32'h0001_FFFC, 32'h0002_0000, 32'h0FFF_FFFC, 32'h1000_0000,
    32'h1000_FFFC, 32'h1001_0000, 32'h1FFF_FFFC, 32'h2000_0000,
    32'h2000_0FFC, 32'h2000_1000
  };

  always #CLK_HALF clk = ~clk;

  mpu_top i_mpu_top (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .instr_core_req_valid_i  (core_valid[0]),
    .instr_core_req_i        (core_req[0]),
    .instr_core_req_ready_o  (core_ready[0]),
    .instr_core_resp_valid_o (resp_valid[0]),
    .instr_core_resp_o       (resp[0]),
    .data_core_req_valid_i   (core_valid[1]),
    .data_core_req_i         (core_req[1]),
    .data_core_req_ready_o   (core_ready[1]),
    .data_core_resp_valid_o  (resp_valid[1]),
    .data_core_resp_o        (resp[1]),
    .bus_req_o               (bus_req),
    .bus_req_valid_o         (bus_valid),
    .bus_req_ready_i         (bus_ready),
    .bus_resp_valid_i        (bus_resp_valid),
    .bus_rdata_i             (bus_rdata)
  );

  function automatic string port_name(input int p);
    return (p == 0) ? "instr" : "data";
  endfunction

  task automatic check_equal(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  task automatic check_idle_outputs();
    for (int p = 0; p < 2; p++) begin
      check_equal({port_name(p), "_core_req_ready_o"}, 64'(core_ready[p]), 64'(0));
      check_equal({port_name(p), "_core_resp_valid_o"}, 64'(resp_valid[p]), 64'(0));
    end
    check_equal("bus_req_valid_o", 64'(bus_valid), 64'(0));
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Region interiors, the overlap, boundaries and unmapped space
  function automatic logic [31:0] pick_addr();
    logic [31:0] addr;
    int unsigned idx;
    case ($urandom_range(0, 6))
      0: addr = $urandom_range(0, 32'h7FFF);
      1: addr = 32'h0000_8000 + $urandom_range(0, 32'h7FFF);
      2: addr = 32'h0001_0000 + $urandom_range(0, 32'hFFFF);
      3: addr = 32'h1000_0000 + $urandom_range(0, 32'hFFFF);
      4: addr = 32'h2000_0000 + $urandom_range(0, 32'hFFF);
      5: begin
        idx = $urandom_range(0, 13);
        addr = EDGE_ADDRS[idx];
      end
      default: addr = $urandom;
    endcase
    return {addr[31:2], 2'b00};
  endfunction

  task automatic new_request(input int p);
    core_req_t   req;
    logic [1:0]  offset;
    req.addr       = pick_addr();
    req.misaligned = ($urandom_range(0, 3) == 0);
    offset         = 2'($urandom_range(1, 3));
    if (req.misaligned) begin
      req.addr[1:0] = offset;
    end
    // Fetches are always reads
    req.we         = (p == 1) && ($urandom_range(0, 1) == 1);
    req.wdata      = $urandom;
    core_req[p]    = req;
    core_valid[p]  = 1'b1;
  endtask

  task automatic drive_inputs(input logic allow_new);
    bus_entry_t head;
    for (int p = 0; p < 2; p++) begin
      if (taken[p]) begin
        core_valid[p] = 1'b0;
        taken[p]      = 1'b0;
      end
      if (allow_new && !core_valid[p] && $urandom_range(0, 99) < 70) begin
        new_request(p);
      end
    end
    // Bus responder, in order after its due cycle
    bus_ready      = ($urandom_range(0, 99) < 75);
    bus_resp_valid = 1'b0;
    bus_rdata      = '0;
    if (bus_q.size() > 0 && bus_q[0].due <= cycle) begin
      head           = bus_q.pop_front();
      bus_resp_valid = 1'b1;
      bus_rdata      = head.addr ^ 32'h5A5A_0000;
    end
  endtask

  //////////////////////////////////////////////////
  // Scoreboard
  //////////////////////////////////////////////////

  task automatic sample_outputs();
    exp_resp_t  exp;
    bus_entry_t entry;
    logic       acc [2];
    logic       blk [2];
    int         allowed_acc;
    int         granted;
    logic       bus_acc;
    allowed_acc = 0;
    granted     = -1;
    bus_acc     = bus_valid && bus_ready;
    // Responses first so outstanding counts match the port in this cycle
    for (int p = 0; p < 2; p++) begin
      if (fault_armed[p] && fault_due[p] == cycle) begin
        check_equal({port_name(p), "_core_resp_valid_o"}, 64'(resp_valid[p]), 64'(1));
        fault_armed[p] = 1'b0;
      end
      if (resp_valid[p]) begin
        if (exp_q[p].size() == 0) begin
          error_count++;
          $display("Response on the %s port at %0t with no request waiting for it",
                   port_name(p), $time);
        end else begin
          exp = exp_q[p].pop_front();
          check_equal({port_name(p), "_core_resp_o.rdata"}, 64'(resp[p].rdata),
                      64'(exp.rdata));
          check_equal({port_name(p), "_core_resp_o.status"}, 64'(resp[p].status),
                      64'(exp.status));
          if (!exp.blocked) begin
            outstanding[p]--;
          end
        end
      end
    end
    for (int p = 0; p < 2; p++) begin
      acc[p] = core_valid[p] && core_ready[p];
      blk[p] = access_blocked(core_req[p].addr, p == 0, core_req[p].misaligned);
      if (acc[p]) begin
        exp.blocked = blk[p];
        exp.rdata   = blk[p] ? '0 : expected_rdata(core_req[p].addr);
        if (!blk[p]) begin
          exp.status = MPU_OK;
        end else if (core_req[p].we) begin
          exp.status = MPU_WR_FAULT;
        end else begin
          exp.status = MPU_RE_FAULT;
        end
        exp_q[p].push_back(exp);
        accepted[p]++;
        taken[p]       = 1'b1;
        pend_cycles[p] = 0;
        passed_over[p] = 0;
        if (!blk[p]) begin
          outstanding[p]++;
          allowed_acc++;
          granted = p;
        end else if (outstanding[p] == 0) begin
          // Nothing in flight, so the fault is due in the next cycle
          fault_armed[p] = 1'b1;
          fault_due[p]   = cycle + 1;
        end
      end
    end
    check_equal("bus_req_valid_o && bus_req_ready_i", 64'(bus_acc), 64'(allowed_acc));
    if (bus_acc) begin
      if (granted >= 0) begin
        check_equal("bus_req_o.addr", 64'(bus_req.addr), 64'(core_req[granted].addr));
        check_equal("bus_req_o.we", 64'(bus_req.we), 64'(core_req[granted].we));
        check_equal("bus_req_o.wdata", 64'(bus_req.wdata), 64'(core_req[granted].wdata));
        check_equal("bus_req_o.memtype", 64'(bus_req.memtype),
                    64'(expected_memtype(core_req[granted].addr, granted == 0,
                                         core_req[granted].we)));
      end
      entry.addr = bus_req.addr;
      entry.due  = cycle + $urandom_range(1, 4);
      bus_q.push_back(entry);
    end
    // Fairness and stuck requests
    for (int p = 0; p < 2; p++) begin
      if (core_valid[p] && !acc[p]) begin
        pend_cycles[p]++;
        if (bus_acc && granted == 1 - p && !blk[p]) begin
          passed_over[p]++;
          if (passed_over[p] == MAX_PASSED + 1) begin
            error_count++;
            $display("The %s port was passed over by more than %0d grants at %0t",
                     port_name(p), MAX_PASSED, $time);
          end
        end
        if (pend_cycles[p] == REQ_TIMEOUT) begin
          error_count++;
          timed_out = 1'b1;
          $display("Timeout: the %s port request waited %0d cycles without being accepted",
                   port_name(p), REQ_TIMEOUT);
        end
      end
    end
  endtask

  task automatic run_cycle(input logic allow_new);
    @(posedge clk);
    cycle++;
    #DRIVE_DELAY;
    drive_inputs(allow_new);
    @(negedge clk);
    sample_outputs();
  endtask

  function automatic logic work_left();
    return (core_valid[0] && !taken[0]) || (core_valid[1] && !taken[1]) ||
           exp_q[0].size() > 0 || exp_q[1].size() > 0 || bus_q.size() > 0;
  endfunction

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int unsigned drain_cycles;
    void'($urandom(SEED));
    rst_n          = 1'b0;
    bus_ready      = 1'b0;
    bus_resp_valid = 1'b0;
    bus_rdata      = '0;
    timed_out      = 1'b0;
    cycle          = 0;
    for (int p = 0; p < 2; p++) begin
      core_valid[p]  = 1'b0;
      core_req[p]    = '0;
      taken[p]       = 1'b0;
      fault_armed[p] = 1'b0;
    end
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      check_idle_outputs();
      @(posedge clk);
    end
    #DRIVE_DELAY;
    rst_n = 1'b1;
    @(negedge clk);
    check_idle_outputs();

    for (int i = 0; i < RUN_CYCLES && !timed_out; i++) begin
      run_cycle(1'b1);
    end

    // Let every request finish
    drain_cycles = 0;
    while (!timed_out && work_left()) begin
      if (drain_cycles == DRAIN_TIMEOUT) begin
        error_count++;
        timed_out = 1'b1;
        $display("Timeout: outstanding requests not drained within %0d cycles",
                 DRAIN_TIMEOUT);
      end else begin
        run_cycle(1'b0);
        drain_cycles++;
      end
    end

    $display("Accepted requests: instr %0d, data %0d", accepted[0], accepted[1]);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mpu_obi.f ====
+incdir+tests
common/mpu_pkg.sv
mpu_port/pma_lookup.sv
mpu_port/mpu_port.sv
source/bus_arbiter.sv
source/mpu_top.sv
tests/tb_mpu_top.sv

// ==== Makefile ====
# Verilator build and run for the MPU testbench

TOP := tb_mpu_top
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -sv --top-module $(TOP) -f mpu_obi.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
